/* snd_board.f */
+incdir+.
snd_pkg.sv
snd_dev_if.sv
snd_bus_ctrl.sv
snd_ram.sv
snd_ctrl_regs.sv
title_player.sv
snd_board.sv
tb_snd_board.sv

/* tb_snd_board.sv */
`timescale 1ns/100ps
`include "snd_cfg.svh"

module tb_snd_board;

    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int ACK_TIMEOUT = 32;

    // output checked after an access
    localparam logic [2:0] CHK_NONE  = 3'd0;
    localparam logic [2:0] CHK_RST   = 3'd1;
    localparam logic [2:0] CHK_LATCH = 3'd2;
    localparam logic [2:0] CHK_PLAY  = 3'd3;
    localparam logic [2:0] CHK_NMI   = 3'd4;

    // side action before an access
    localparam logic [1:0] ACT_NONE    = 2'd0;
    localparam logic [1:0] ACT_TICK    = 2'd1;
    localparam logic [1:0] ACT_BUSY_LO = 2'd2;
    localparam logic [1:0] ACT_BUSY_HI = 2'd3;

    typedef struct packed {
        snd_pkg::game_e game;
        logic           wr;
        logic [15:0]    addr;
        logic [7:0]     wdata;
        logic [7:0]     exp_rd;
        logic [2:0]     chk;
        logic [7:0]     exp_out;
        logic [1:0]     act;
    } access_t;

    logic                   clk;
    logic                   rst;
    snd_pkg::game_e         game;
    logic                   req;
    logic                   wr;
    logic [`SND_ADDR_W-1:0] addr;
    logic [7:0]             wdata;
    logic                   ack;
    logic [7:0]             rdata;
    logic [`SND_ROM_AW-1:0] rom_addr;
    logic                   rom_cs;
    logic [7:0]             rom_data;
    logic                   rom_ok;
    logic [`SND_TITLE_AW:1] title_addr;
    logic [15:0]            title_data;
    logic                   cen_20;
    logic [7:0]             snd_latch;
    logic                   upd_busyn;
    logic                   sample_tick;
    logic                   upd_rst;
    logic [7:0]             upd_latch;
    logic                   upd_play;
    logic                   nmi_n;
    logic signed [15:0]     title;

    logic [31:0]        lfsr;
    access_t            tab[$];
    access_t            e;
    logic [15:0]        title_tab [0:7];
    logic [7:0]         rd;
    logic [7:0]         obs;
    logic [15:0]        word;
    logic [`SND_TITLE_AW:1] prev_addr;
    logic signed [15:0] exp_title;
    logic               cs;
    logic               exp_cs;
    logic               abort;
    logic               rom_busy;
    int                 rom_cnt;
    int                 errors;
    int                 err_before;
    int                 tests;
    int                 i;

    snd_board u_snd_board (.*);

    always #10 clk = ~clk;

    // Galois LFSR stepped once per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    // expected sample for one title ROM word
    function automatic logic signed [15:0] title_decode(input logic [15:0] w);
        int m;
        int div;
        int q;
        m   = w[12] ? int'(w[11:3]) : int'(w[11:3]) - 512;  // sign stored inverted
        div = 1 << (7 - w[15:13]);
        q   = (m * 64) / div;
        if (m < 0 && (m * 64) % div != 0) begin
            q = q - 1;  // arithmetic shift rounds down
        end
        return q[15:0];
    endfunction

    // program ROM window of each map
    function automatic logic rom_target(input snd_pkg::game_e g, input logic [15:0] a);
        if (g == snd_pkg::GAME_PUNK) begin
            return a < 16'hf000;
        end
        return a < 16'h8000;
    endfunction

    function automatic string state_name(input snd_pkg::bus_st_e st);
        case (st)
            snd_pkg::ST_IDLE:    return "ST_IDLE";
            snd_pkg::ST_DECODE:  return "ST_DECODE";
            snd_pkg::ST_ROMWAIT: return "ST_ROMWAIT";
            default:             return "ST_ACK";
        endcase
    endfunction

    function automatic logic [7:0] observe(input logic [2:0] kind);
        case (kind)
            CHK_RST:   return {7'd0, upd_rst};
            CHK_LATCH: return upd_latch;
            CHK_PLAY:  return {7'd0, upd_play};
            default:   return {7'd0, nmi_n};
        endcase
    endfunction

    function automatic string chk_name(input logic [2:0] kind);
        case (kind)
            CHK_RST:   return "upd_rst";
            CHK_LATCH: return "upd_latch";
            CHK_PLAY:  return "upd_play";
            default:   return "nmi_n";
        endcase
    endfunction

    // program ROM answers after 0 to 3 extra cycles
    always @(negedge clk) begin
        if (!rom_cs) begin
            rom_ok   <= 1'b0;
            rom_busy <= 1'b0;
        end else if (!rom_busy) begin
            rom_busy <= 1'b1;
            rom_cnt  <= rand_bits(2);
        end else if (rom_cnt == 0) begin
            rom_ok   <= 1'b1;
            rom_data <= rom_addr[7:0] ^ 8'h5a;
        end else begin
            rom_cnt <= rom_cnt - 1;
        end
    end

    // title ROM with the upper address bits folded in
    assign title_data = title_tab[title_addr[3:1]] ^ {1'b0, title_addr[18:4]};

    task automatic add_access(input snd_pkg::game_e g, input logic w, input logic [15:0] a,
                              input logic [7:0] d, input logic [7:0] er, input logic [2:0] c,
                              input logic [7:0] eo, input logic [1:0] act);
        access_t t;
        t = {g, w, a, d, er, c, eo, act};
        tab.push_back(t);
    endtask

    task automatic build_table();
        logic [15:0] a;
        logic [10:0] off;
        logic [7:0]  d;
        int          k;
        for (k = 0; k < 4; k++) begin
            a = rand_bits(15);  // below 8000
            add_access(snd_pkg::GAME_STD, 1'b0, a, 8'h00, a[7:0] ^ 8'h5a, CHK_NONE, 8'h00,
                       ACT_NONE);
            a = rand_bits(16);
            if (a[15:12] == 4'hf) begin
                a[15] = 1'b0;
            end
            add_access(snd_pkg::GAME_PUNK, 1'b0, a, 8'h00, a[7:0] ^ 8'h5a, CHK_NONE, 8'h00,
                       ACT_NONE);
        end
        for (k = 0; k < 3; k++) begin
            off = rand_bits(11);
            d   = rand_bits(8);
            add_access(snd_pkg::GAME_STD, 1'b1, {5'b10000, off}, d, 8'h00, CHK_NONE, 8'h00,
                       ACT_NONE);
            add_access(snd_pkg::GAME_STD, 1'b0, {5'b10000, off}, 8'h00, d, CHK_NONE, 8'h00,
                       ACT_NONE);
            add_access(snd_pkg::GAME_PUNK, 1'b0, {5'b11110, off}, 8'h00, d, CHK_NONE, 8'h00,
                       ACT_NONE);
            add_access(snd_pkg::GAME_PUNK, 1'b1, {5'b11110, off}, ~d, 8'h00, CHK_NONE, 8'h00,
                       ACT_NONE);
            // 8800 mirror of the same cell
            add_access(snd_pkg::GAME_STD, 1'b0, {5'b10001, off}, 8'h00, ~d, CHK_NONE, 8'h00,
                       ACT_NONE);
        end
        d = rand_bits(8);
        add_access(snd_pkg::GAME_STD, 1'b1, 16'h9000, 8'h02, 8'h00, CHK_RST, 8'h00, ACT_NONE);
        add_access(snd_pkg::GAME_STD, 1'b1, 16'h9000, 8'h00, 8'h00, CHK_RST, 8'h01, ACT_NONE);
        add_access(snd_pkg::GAME_STD, 1'b1, 16'hd000, d, 8'h00, CHK_LATCH, d, ACT_NONE);
        add_access(snd_pkg::GAME_STD, 1'b1, 16'he000, 8'h01, 8'h00, CHK_PLAY, 8'h00, ACT_NONE);
        add_access(snd_pkg::GAME_STD, 1'b1, 16'he000, 8'h00, 8'h00, CHK_PLAY, 8'h01, ACT_NONE);
        add_access(snd_pkg::GAME_STD, 1'b0, 16'ha000, 8'h00, 8'ha7, CHK_NONE, 8'h00, ACT_NONE);
        add_access(snd_pkg::GAME_STD, 1'b0, 16'hf000, 8'h00, 8'h00, CHK_NONE, 8'h00,
                   ACT_BUSY_LO);
        add_access(snd_pkg::GAME_STD, 1'b0, 16'hf000, 8'h00, 8'h01, CHK_NONE, 8'h00,
                   ACT_BUSY_HI);
        add_access(snd_pkg::GAME_STD, 1'b0, 16'hb123, 8'h00, `SND_OPEN_BUS, CHK_NONE, 8'h00,
                   ACT_NONE);
        add_access(snd_pkg::GAME_STD, 1'b0, 16'hc000, 8'h00, `SND_OPEN_BUS, CHK_NONE, 8'h00,
                   ACT_NONE);
        // NMI set by the tick and cleared only through the alternate map
        add_access(snd_pkg::GAME_STD, 1'b0, 16'hf000, 8'h00, 8'h01, CHK_NMI, 8'h00, ACT_TICK);
        add_access(snd_pkg::GAME_STD, 1'b1, 16'hfa00, 8'h55, 8'h00, CHK_NMI, 8'h00, ACT_NONE);
        add_access(snd_pkg::GAME_STD, 1'b0, 16'hfa00, 8'h00, 8'h01, CHK_NMI, 8'h00, ACT_NONE);
        add_access(snd_pkg::GAME_PUNK, 1'b0, 16'hfa00, 8'h00, `SND_OPEN_BUS, CHK_NMI, 8'h01,
                   ACT_NONE);
        add_access(snd_pkg::GAME_PUNK, 1'b0, 16'hf900, 8'h00, `SND_OPEN_BUS, CHK_NMI, 8'h00,
                   ACT_TICK);
        add_access(snd_pkg::GAME_PUNK, 1'b1, 16'hfb00, 8'h00, 8'h00, CHK_NMI, 8'h01, ACT_NONE);
    endtask

    task automatic apply_action(input logic [1:0] act);
        if (act == ACT_TICK) begin
            @(negedge clk);
            sample_tick = 1'b1;
            @(negedge clk);
            sample_tick = 1'b0;
            @(negedge clk);
        end else if (act == ACT_BUSY_LO) begin
            upd_busyn = 1'b0;
        end else if (act == ACT_BUSY_HI) begin
            upd_busyn = 1'b1;
        end
    endtask

    // one four-phase access with rdata sampled while ack is high
    task automatic do_access(input snd_pkg::game_e g, input logic w, input logic [15:0] a,
                             input logic [7:0] d, output logic [7:0] r,
                             output logic cs_seen);
        int n;
        @(negedge clk);
        game    = g;
        wr      = w;
        addr    = a;
        wdata   = d;
        req     = 1'b1;
        n       = 0;
        r       = 8'h00;
        cs_seen = 1'b0;
        while (!ack && n < ACK_TIMEOUT) begin
            @(negedge clk);
            cs_seen = cs_seen | rom_cs;
            n++;
        end
        if (!ack) begin
            $display("Timeout waiting for ack at addr %h, controller in %s", a,
                     state_name(u_snd_board.u_bus_ctrl.state));
            errors++;
            abort = 1'b1;
        end
        r   = rdata;
        req = 1'b0;
        n   = 0;
        while (ack && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (ack) begin
            $display("Timeout waiting for ack to drop at addr %h, controller in %s", a,
                     state_name(u_snd_board.u_bus_ctrl.state));
            errors++;
            abort = 1'b1;
        end
    endtask

    task automatic pulse_cen();
        @(negedge clk);
        cen_20 = 1'b1;
        @(negedge clk);
        cen_20 = 1'b0;
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        game        = snd_pkg::GAME_STD;
        req         = 1'b0;
        wr          = 1'b0;
        addr        = '0;
        wdata       = 8'h00;
        rom_data    = 8'h00;
        rom_ok      = 1'b0;
        rom_busy    = 1'b0;
        rom_cnt     = 0;
        cen_20      = 1'b0;
        snd_latch   = 8'ha7;
        upd_busyn   = 1'b1;
        sample_tick = 1'b0;
        lfsr        = 32'hf946_bdcc;
        errors      = 0;
        tests       = 0;
        abort       = 1'b0;
        title_tab   = '{16'hffff, 16'he5a8, 16'h1234, 16'h8ff8,
                        16'h7001, 16'h3c48, 16'h0ff0, 16'ha5a5};
        build_table();
        repeat (10) @(negedge clk);
        rst = 1'b0;

        for (i = 0; i < tab.size() && !abort; i++) begin
            e          = tab[i];
            err_before = errors;
            apply_action(e.act);
            do_access(e.game, e.wr, e.addr, e.wdata, rd, cs);
            exp_cs = rom_target(e.game, e.addr) && !e.wr;
            if (!abort && !e.wr && rd !== e.exp_rd) begin
                $display("Mismatch rdata test %0d: got %h, expected %h", i, rd, e.exp_rd);
                errors++;
            end
            if (!abort && cs !== exp_cs) begin
                $display("Mismatch rom_cs test %0d: got %h, expected %h", i, cs, exp_cs);
                errors++;
            end
            if (!abort && exp_cs && rom_addr !== e.addr[`SND_ROM_AW-1:0]) begin
                $display("Mismatch rom_addr test %0d: got %h, expected %h", i, rom_addr,
                         e.addr[`SND_ROM_AW-1:0]);
                errors++;
            end
            if (!abort && e.chk != CHK_NONE) begin
                obs = observe(e.chk);
                if (obs !== e.exp_out) begin
                    $display("Mismatch %s test %0d: got %h, expected %h", chk_name(e.chk), i,
                             obs, e.exp_out);
                    errors++;
                end
            end
            tests++;
            $display("test %0d %s addr %h: %s", i, e.wr ? "wr" : "rd", e.addr,
                     (errors == err_before) ? "ok" : "FAIL");
        end

        if (!abort) begin
            // title player still held by title_rstn
            err_before = errors;
            repeat (3) pulse_cen();
            if (title !== 16'sd0 || title_addr !== '0) begin
                $display("Mismatch title in reset: got %h at addr %h, expected 0", title,
                         title_addr);
                errors++;
            end
            tests++;
            $display("test %0d title held: %s", tests, (errors == err_before) ? "ok" : "FAIL");
            do_access(snd_pkg::GAME_STD, 1'b1, 16'h9000, 8'h06, rd, cs);
            for (i = 0; i < 10 && !abort; i++) begin
                err_before = errors;
                prev_addr  = title_addr;
                word       = title_data;
                exp_title  = title_decode(word);
                pulse_cen();
                if (title_addr !== prev_addr + 1'b1) begin
                    $display("Mismatch title_addr: got %h, expected %h", title_addr,
                             prev_addr + 1'b1);
                    errors++;
                end
                if (title !== exp_title) begin
                    $display("Mismatch title for word %h: got %h, expected %h", word, title,
                             exp_title);
                    errors++;
                end
                tests++;
                $display("test %0d title step %0d: %s", tests, i,
                         (errors == err_before) ? "ok" : "FAIL");
            end
        end

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* snd_board.sv */
`timescale 1ns/100ps
`include "snd_cfg.svh"

module snd_board (
    input  logic                       clk,
    input  logic                       rst,
    input  snd_pkg::game_e             game,
    // host bus
    input  logic                       req,
    input  logic                       wr,
    input  logic [`SND_ADDR_W-1:0]     addr,
    input  logic [7:0]                 wdata,
    output logic                       ack,
    output logic [7:0]                 rdata,
    // program ROM
    output logic [`SND_ROM_AW-1:0]     rom_addr,
    output logic                       rom_cs,
    input  logic [7:0]                 rom_data,
    input  logic                       rom_ok,
    // title ROM
    output logic [`SND_TITLE_AW:1]     title_addr,
    input  logic [15:0]                title_data,
    input  logic                       cen_20,
    // sample chip, latch and NMI
    input  logic [7:0]                 snd_latch,
    input  logic                       upd_busyn,
    input  logic                       sample_tick,
    output logic                       upd_rst,
    output logic [7:0]                 upd_latch,
    output logic                       upd_play,
    output logic                       nmi_n,
    output logic signed [15:0]         title
);

    logic title_rstn;

    snd_dev_if u_dev ();

    snd_bus_ctrl u_bus_ctrl (
        .clk        (clk),
        .rst        (rst),
        .game       (game),
        .req        (req),
        .wr         (wr),
        .addr       (addr),
        .wdata      (wdata),
        .ack        (ack),
        .rdata      (rdata),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .bus        (u_dev.ctrl)
    );

    snd_ram u_ram (
        .clk        (clk),
        .bus        (u_dev.ram)
    );

    snd_ctrl_regs u_ctrl_regs (
        .clk         (clk),
        .rst         (rst),
        .snd_latch   (snd_latch),
        .upd_busyn   (upd_busyn),
        .sample_tick (sample_tick),
        .bus         (u_dev.regs),
        .upd_rst     (upd_rst),
        .upd_latch   (upd_latch),
        .upd_play    (upd_play),
        .title_rstn  (title_rstn),
        .nmi_n       (nmi_n)
    );

    title_player u_title (
        .clk         (clk),
        .rst         (rst),
        .cen_20      (cen_20),
        .title_rstn  (title_rstn),
        .title_data  (title_data),
        .title_addr  (title_addr),
        .title       (title)
    );

endmodule

/* title_player.sv */
`timescale 1ns/100ps
`include "snd_cfg.svh"

module title_player (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cen_20,
    input  logic                       title_rstn,
    input  logic [15:0]                title_data,
    output logic [`SND_TITLE_AW:1]     title_addr,
    output logic signed [15:0]         title
);

    logic signed [15:0] title_raw;
    logic [2:0]         shift;

    // sign is inverted bit 12 above nine left-justified mantissa bits
    assign title_raw = {~title_data[12], title_data[11:3], 6'd0};
    assign shift     = ~title_data[15:13];  // attenuation exponent

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            title_addr <= '0;
            title      <= 16'sd0;
        end else if (!title_rstn) begin
            title_addr <= '0;
            title      <= 16'sd0;
        end else if (cen_20) begin
            title_addr <= title_addr + 1'b1;
            title      <= title_raw >>> shift;
        end
    end

    // cen_20 is a single-cycle enable from the clock divider
    a_cen_single: assert property (
        @(posedge clk) disable iff (rst) cen_20 |=> !cen_20
    );

endmodule

/* snd_ctrl_regs.sv */
`timescale 1ns/100ps

module snd_ctrl_regs (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] snd_latch,
    input  logic       upd_busyn,
    input  logic       sample_tick,
    snd_dev_if.regs    bus,
    output logic       upd_rst,
    output logic [7:0] upd_latch,
    output logic       upd_play,    // start, active low at the chip
    output logic       title_rstn,
    output logic       nmi_n
);

    logic upd_rstn;
    logic tick_q;
    logic tick_rise;
    logic nmi_clr;

    assign upd_rst = ~upd_rstn;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            upd_rstn   <= 1'b0;
            title_rstn <= 1'b0;
            upd_latch  <= 8'd0;
            upd_play   <= 1'b1;
        end else if (bus.wr_stb) begin
            case (bus.sel)
                snd_pkg::DEV_SRES: begin
                    upd_rstn   <= bus.wdata[1];
                    title_rstn <= bus.wdata[2];
                end
                snd_pkg::DEV_VDIN: upd_latch <= bus.wdata;
                snd_pkg::DEV_VST:  upd_play  <= ~bus.wdata[0];
                default: ;
            endcase
        end
    end

    // read side, latch and busy flag only
    always_ff @(posedge clk) begin
        if (bus.rd_stb) begin
            if (bus.sel == snd_pkg::DEV_LATCH) begin
                bus.reg_rdata <= snd_latch;
            end else if (bus.sel == snd_pkg::DEV_BUSY) begin
                bus.reg_rdata <= {7'd0, upd_busyn};
            end
        end
    end

    assign tick_rise = sample_tick && !tick_q;
    assign nmi_clr   = (bus.rd_stb || bus.wr_stb) && (bus.sel == snd_pkg::DEV_NMICLR);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_q <= 1'b0;
            nmi_n  <= 1'b1;
        end else begin
            tick_q <= sample_tick;
            if (nmi_clr) begin
                nmi_n <= 1'b1;      // clear wins over a new tick
            end else if (tick_rise) begin
                nmi_n <= 1'b0;
            end
        end
    end

    a_stb_onehot: assert property (
        @(posedge clk) disable iff (rst) !(bus.rd_stb && bus.wr_stb)
    );
    // strobes come from the controller's decode state, one cycle each
    a_stb_single: assert property (
        @(posedge clk) disable iff (rst) (bus.rd_stb || bus.wr_stb) |=> !(bus.rd_stb || bus.wr_stb)
    );

endmodule

/* snd_ram.sv */
`timescale 1ns/100ps
`include "snd_cfg.svh"

module snd_ram (
    input  logic   clk,
    snd_dev_if.ram bus
);

    logic [7:0]             mem [0:(1 << `SND_RAM_AW) - 1];
    logic [`SND_RAM_AW-1:0] ra;
    logic                   hit;

    assign ra  = bus.a[`SND_RAM_AW-1:0];   // upper bits alias, as on the board
    assign hit = (bus.sel == snd_pkg::DEV_RAM);

    always_ff @(posedge clk) begin
        if (bus.wr_stb && hit) begin
            mem[ra] <= bus.wdata;
        end
    end

    // read port, held until the next read
    always_ff @(posedge clk) begin
        if (bus.rd_stb && hit) begin
            bus.ram_rdata <= mem[ra];
        end
    end

    // a write never runs into a read on the next cycle
    a_no_back_to_back: assert property (
        @(posedge clk) (bus.wr_stb && hit) |=> !bus.rd_stb
    );

endmodule

/* snd_bus_ctrl.sv */
`timescale 1ns/100ps
`include "snd_cfg.svh"

module snd_bus_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  snd_pkg::game_e         game,
    // host side, four-phase req/ack
    input  logic                   req,
    input  logic                   wr,
    input  logic [`SND_ADDR_W-1:0] addr,
    input  logic [7:0]             wdata,
    output logic                   ack,
    output logic [7:0]             rdata,
    // program ROM
    output logic [`SND_ROM_AW-1:0] rom_addr,
    output logic                   rom_cs,
    input  logic [7:0]             rom_data,
    input  logic                   rom_ok,
    snd_dev_if.ctrl                bus
);

    snd_pkg::bus_st_e       state;
    snd_pkg::dev_e          dev_dec;
    snd_pkg::dev_e          sel_q;
    logic [`SND_ADDR_W-1:0] a_q;
    logic                   wr_q;
    logic [7:0]             wdata_q;
    logic [7:0]             rom_q;
    logic                   rom_rd;

    // address decode, one map per game
    always_comb begin
        dev_dec = snd_pkg::DEV_NONE;
        if (game == snd_pkg::GAME_PUNK) begin
            if (addr[15:12] != 4'hf) begin
                dev_dec = snd_pkg::DEV_ROM;         // 0000-EFFF
            end else if (!addr[11]) begin
                dev_dec = snd_pkg::DEV_RAM;         // F000-F7FF
            end else if (addr[11:9] == 3'd5) begin
                dev_dec = snd_pkg::DEV_NMICLR;      // FAxx-FBxx
            end
        end else begin
            if (!addr[15]) begin
                dev_dec = snd_pkg::DEV_ROM;
            end else begin
                case (addr[14:12])
                    3'd0: dev_dec = snd_pkg::DEV_RAM;   // 8xxx
                    3'd1: dev_dec = snd_pkg::DEV_SRES;  // 9xxx
                    3'd2: dev_dec = snd_pkg::DEV_LATCH; // Axxx
                    3'd5: dev_dec = snd_pkg::DEV_VDIN;  // Dxxx
                    3'd6: dev_dec = snd_pkg::DEV_VST;   // Exxx
                    3'd7: dev_dec = snd_pkg::DEV_BUSY;  // Fxxx
                    default: dev_dec = snd_pkg::DEV_NONE; // FM and DAC, not modelled
                endcase
            end
        end
    end

    assign rom_rd = (sel_q == snd_pkg::DEV_ROM) && !wr_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= snd_pkg::ST_IDLE;
            sel_q <= snd_pkg::DEV_NONE;
            ack   <= 1'b0;
        end else begin
            case (state)
                snd_pkg::ST_IDLE: begin
                    if (req) begin
                        state <= snd_pkg::ST_DECODE;
                        sel_q <= dev_dec;
                    end
                end
                snd_pkg::ST_DECODE: begin
                    if (rom_rd) begin
                        state <= snd_pkg::ST_ROMWAIT;
                    end else begin
                        state <= snd_pkg::ST_ACK;   // strobe fires this cycle
                        ack   <= 1'b1;
                    end
                end
                snd_pkg::ST_ROMWAIT: begin
                    if (rom_ok) begin
                        state <= snd_pkg::ST_ACK;
                        ack   <= 1'b1;
                    end
                end
                snd_pkg::ST_ACK: begin
                    if (!req) begin
                        state <= snd_pkg::ST_IDLE;
                        ack   <= 1'b0;
                    end
                end
                default: state <= snd_pkg::ST_IDLE;
            endcase
        end
    end

    // access payload, held until the next request
    always_ff @(posedge clk) begin
        if (state == snd_pkg::ST_IDLE && req) begin
            a_q     <= addr;
            wr_q    <= wr;
            wdata_q <= wdata;
        end
        if (state == snd_pkg::ST_ROMWAIT && rom_ok) begin
            rom_q <= rom_data;
        end
    end

    assign rom_addr = a_q[`SND_ROM_AW-1:0];
    assign rom_cs   = rom_rd && (state == snd_pkg::ST_DECODE ||
                                 state == snd_pkg::ST_ROMWAIT);

    assign bus.sel    = sel_q;
    assign bus.a      = a_q[11:0];
    assign bus.wdata  = wdata_q;
    assign bus.rd_stb = (state == snd_pkg::ST_DECODE) && !wr_q &&
                        (sel_q != snd_pkg::DEV_ROM);
    assign bus.wr_stb = (state == snd_pkg::ST_DECODE) && wr_q;

    // every source below is a register, so rdata holds while ack is up
    always_comb begin
        case (sel_q)
            snd_pkg::DEV_ROM:   rdata = rom_q;
            snd_pkg::DEV_RAM:   rdata = bus.ram_rdata;
            snd_pkg::DEV_LATCH: rdata = bus.reg_rdata;
            snd_pkg::DEV_BUSY:  rdata = bus.reg_rdata;
            default:            rdata = `SND_OPEN_BUS;
        endcase
    end

    // the host must still be holding req on the cycle ack goes up
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (rst) $rose(ack) |-> $past(req)
    );

endmodule

/* snd_dev_if.sv */
`timescale 1ns/100ps

interface snd_dev_if;
    snd_pkg::dev_e sel;       // target of the access in flight
    logic          rd_stb;    // single cycle
    logic          wr_stb;    // single cycle
    logic [11:0]   a;
    logic [7:0]    wdata;
    logic [7:0]    ram_rdata;
    logic [7:0]    reg_rdata;

    modport ctrl (
        output sel,
        output rd_stb,
        output wr_stb,
        output a,
        output wdata,
        input  ram_rdata,
        input  reg_rdata
    );

    modport ram (
        input  sel,
        input  rd_stb,
        input  wr_stb,
        input  a,
        input  wdata,
        output ram_rdata
    );

    // control registers only need the select, no address bits
    modport regs (
        input  sel,
        input  rd_stb,
        input  wr_stb,
        input  wdata,
        output reg_rdata
    );
endinterface

/* snd_pkg.sv */
package snd_pkg;

    // memory map selection
    typedef enum logic [0:0] {
        GAME_STD  = 1'b0,
        GAME_PUNK = 1'b1
    } game_e;

    // decoded bus target
    typedef enum logic [3:0] {
        DEV_NONE,
        DEV_ROM,
        DEV_RAM,
        DEV_SRES,   // sample chip and title reset bits
        DEV_LATCH,  // command latch from main CPU
        DEV_VDIN,
        DEV_VST,
        DEV_BUSY,
        DEV_NMICLR  // alternate map only
    } dev_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DECODE,
        ST_ROMWAIT,
        ST_ACK
    } bus_st_e;

endpackage

/* snd_cfg.svh */
`ifndef SND_CFG_SVH
`define SND_CFG_SVH

// work RAM, 2 KB
`define SND_RAM_AW 11

// sound CPU address bus
`define SND_ADDR_W 16

// external program ROM, 32 KB window
`define SND_ROM_AW 15

// title theme ROM, 16-bit words
`define SND_TITLE_AW 18

// pulled-up data bus on undecoded reads
`define SND_OPEN_BUS 8'hff

`endif
